//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --assert -j 0 --top-module tb_video_top -f all.f -o tb_video_top
	@out=$$(./obj_dir/tb_video_top); echo "$$out"; \
	echo "$$out" | grep -qx "Simulation finished: PASS"

clean:
	rm -rf obj_dir

//--- all.f
vid_pkg.sv
bus_regs.sv
intr_ctrl.sv
video_timing.sv
pixel_fetch.sv
vram_arb.sv
color_lookup.sv
video_top.sv
tb_video_top.sv

//--- bus_regs.sv
`timescale 1ns/1ps

module bus_regs import vid_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,
    input  bus_req_t   bus_i,
    output logic [7:0] bus_data_o,
    output mem_req_t   regs_req_o,
    input  logic       regs_ack_i,
    input  word_t      vram_data_i,
    output logic       xr_wr_o,
    output color_t     xr_addr_o,
    output word_t      xr_data_o,
    output intr_cmd_t  intr_cmd_o,
    input  intr_t      intr_status_i,
    input  logic       hblank_i,
    input  logic       vblank_i
);

logic       wr_acc;         // write access this cycle
logic       rd_acc;         // read access this cycle
logic       odd_wr;         // odd byte write, commits a word
logic [7:0] hold_byte;      // even byte waiting for its odd half
word_t      wr_word;
vaddr_t     wr_addr;
vaddr_t     rd_addr;
word_t      rd_data;
color_t     xr_addr;
logic       mem_busy;       // vram request outstanding
logic       rd_pending;     // read data lands on the bus this cycle
word_t      rd_word;        // read mux before byte select

assign wr_acc  = !bus_i.cs_n && !bus_i.rd_nwr;
assign rd_acc  = !bus_i.cs_n && bus_i.rd_nwr;
assign odd_wr  = wr_acc && bus_i.bytesel;
assign wr_word = {hold_byte, bus_i.data};       // even byte is high

// INT_CTRL acts per byte, no holding byte
always_comb begin
    intr_cmd_o.mask_wr  = wr_acc && !bus_i.bytesel && (bus_i.reg_num == R_INT_CTRL);
    intr_cmd_o.clear_wr = odd_wr && (bus_i.reg_num == R_INT_CTRL);
    intr_cmd_o.value    = bus_i.data;
end

// color memory write, one entry per odd byte
assign xr_wr_o   = odd_wr && (bus_i.reg_num == R_XR_DATA);
assign xr_addr_o = xr_addr;
assign xr_data_o = wr_word;

always_ff @(posedge clk) begin
    if (reset_i) begin
        wr_addr        <= '0;
        rd_addr        <= '0;
        xr_addr        <= '0;
        mem_busy       <= 1'b0;
        rd_pending     <= 1'b0;
        regs_req_o.sel <= 1'b0;
        regs_req_o.wr  <= 1'b0;
    end else begin
        rd_pending <= 1'b0;
        if (regs_ack_i) begin
            regs_req_o.sel <= 1'b0;             // drop request once granted
            rd_pending     <= !regs_req_o.wr;
            if (regs_req_o.wr) begin
                mem_busy <= 1'b0;               // write done at ack
            end
        end
        if (rd_pending) begin
            mem_busy <= 1'b0;                   // read done at capture
        end
        if (odd_wr) begin
            case (bus_i.reg_num)
                R_WR_ADDR: wr_addr <= wr_word[7:0];
                R_WR_DATA: begin
                    if (!mem_busy) begin        // ignored while busy
                        regs_req_o <= '{sel: 1'b1, wr: 1'b1, addr: wr_addr, data: wr_word};
                        wr_addr    <= wr_addr + 1'b1;
                        mem_busy   <= 1'b1;
                    end
                end
                R_RD_ADDR: begin
                    rd_addr <= wr_word[7:0];
                    if (!mem_busy) begin
                        regs_req_o <= '{sel: 1'b1, wr: 1'b0, addr: wr_word[7:0], data: '0};
                        mem_busy   <= 1'b1;
                    end
                end
                R_XR_ADDR: xr_addr <= wr_word[7:0];
                R_XR_DATA: xr_addr <= xr_addr + 1'b1;   // entry written this cycle
                default: ;
            endcase
        end
    end
end

// register read mux, word view
always_comb begin
    rd_word = '0;
    case (bus_i.reg_num)
        R_INT_CTRL: rd_word = {14'h0, intr_status_i};   // pending bits in odd byte
        R_STATUS:   rd_word = {13'h0, mem_busy, vblank_i, hblank_i};
        R_WR_ADDR:  rd_word = {8'h00, wr_addr};
        R_RD_ADDR:  rd_word = {8'h00, rd_addr};
        R_RD_DATA:  rd_word = rd_data;
        R_XR_ADDR:  rd_word = {8'h00, xr_addr};
        default:    rd_word = '0;
    endcase
end

always_ff @(posedge clk) begin
    if (wr_acc && !bus_i.bytesel && (bus_i.reg_num != R_INT_CTRL)) begin
        hold_byte <= bus_i.data;
    end
    if (rd_pending) begin
        rd_data <= vram_data_i;                 // one cycle after ack
    end
    if (rd_acc) begin
        bus_data_o <= bus_i.bytesel ? rd_word[7:0] : rd_word[15:8];    // held until next read
    end
end

endmodule

//--- color_lookup.sv
`timescale 1ns/1ps

module color_lookup import vid_pkg::*; (
    input  logic   clk,
    input  logic   reset_i,
    input  logic   xr_wr_i,
    input  color_t xr_addr_i,
    input  word_t  xr_data_i,
    input  color_t color_index_i,
    input  sync_t  sync_i,
    output rgb_t   rgb_o,
    output sync_t  sync_o
);

color_word_u colormem [2**COLOR_AW];
color_word_u entry;         // current pixel's entry

always_ff @(posedge clk) begin
    if (xr_wr_i) begin
        colormem[xr_addr_i].raw <= xr_data_i;
    end
end

assign entry = colormem[color_index_i];

always_ff @(posedge clk) begin
    if (reset_i) begin
        rgb_o  <= '0;
        sync_o <= '0;
    end else begin
        rgb_o  <= sync_i.de ? entry.argb.rgb : '0;     // black outside display
        sync_o <= sync_i;                               // third sync delay
    end
end

endmodule

//--- intr_ctrl.sv
`timescale 1ns/1ps

module intr_ctrl import vid_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  intr_cmd_t intr_cmd_i,
    input  intr_t     trigger_i,
    output intr_t     status_o,
    output logic      bus_intr_o
);

intr_t mask;        // enabled sources
intr_t clear;       // bits the host acknowledges

assign clear = intr_cmd_i.clear_wr ? intr_cmd_i.value[1:0] : '0;

always_ff @(posedge clk) begin
    if (reset_i) begin
        mask       <= '0;
        status_o   <= '0;
        bus_intr_o <= 1'b0;
    end else begin
        // pulse only for enabled sources not already pending
        bus_intr_o <= |(trigger_i & mask & ~status_o);
        if (intr_cmd_i.mask_wr) begin
            mask <= intr_cmd_i.value[1:0];
        end
        status_o <= (status_o | trigger_i) & ~clear;    // sticky, masked or not
    end
end

endmodule

//--- pixel_fetch.sv
`timescale 1ns/1ps

module pixel_fetch import vid_pkg::*; (
    input  logic   clk,
    input  hpos_t  h_pos_i,
    input  vpos_t  v_pos_i,
    input  sync_t  sync_i,
    output logic   vram_sel_o,
    output vaddr_t vram_addr_o,
    input  word_t  vram_data_i,
    output color_t color_index_o,
    output sync_t  sync_o
);

logic  fetch_d;     // word on vram_data_i is ours
word_t word_hold;   // kept for the odd pixel, bus may be reused
sync_t sync_d;

// one fetch per pixel pair, on the even pixel
assign vram_sel_o  = sync_i.de && !h_pos_i[0];
assign vram_addr_o = vaddr_t'(v_pos_i) * vaddr_t'(WORDS_PER_LINE) + vaddr_t'(h_pos_i >> 1);

always_ff @(posedge clk) begin
    fetch_d <= vram_sel_o;
    if (fetch_d) begin
        word_hold <= vram_data_i;
    end
    // high byte for even x, low byte one cycle later
    color_index_o <= fetch_d ? vram_data_i[15:8] : word_hold[7:0];
    sync_d        <= sync_i;
    sync_o        <= sync_d;    // two cycles, matches color index
end

endmodule

//--- tb_video_top.sv
`timescale 1ns/1ps

module tb_video_top import vid_pkg::*; ();

logic       clk = 1'b0;
logic       reset_i;
bus_req_t   bus;
logic [7:0] bus_data;
logic       bus_intr;
rgb_t       rgb;
sync_t      sync;

logic [31:0] rng_state;
logic [15:0] vram_model [256];     // expected VRAM contents
logic [15:0] color_model [256];    // expected color entries, rgb in low 12 bits
int          checks;
int          errors;

video_top uut (
    .clk(clk),
    .reset_i(reset_i),
    .bus_i(bus),
    .bus_data_o(bus_data),
    .bus_intr_o(bus_intr),
    .rgb_o(rgb),
    .sync_o(sync)
);

always #5 clk = ~clk;     // 10 ns period

function automatic logic [31:0] next_rand();
    logic [31:0] s;
    s = rng_state;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    rng_state = s;
    return s;
endfunction

task automatic check_value(input string name, input logic [15:0] got, input logic [15:0] exp);
    checks++;
    assert (got === exp) else begin
        errors++;
        $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
    end
endtask

// one bus cycle, entered and left on a falling edge
task automatic bus_access(input logic rd, input logic [3:0] reg_num, input logic odd,
                          input logic [7:0] data, output logic [7:0] rdata);
    bus = '{cs_n: 1'b0, rd_nwr: rd, reg_num: reg_num, bytesel: odd, data: data};
    @(negedge clk);
    bus.cs_n = 1'b1;
    rdata = bus_data;     // registered on the edge in between
endtask

task automatic write_byte(input logic [3:0] reg_num, input logic odd, input logic [7:0] b);
    logic [7:0] unused_rd;
    bus_access(1'b0, reg_num, odd, b, unused_rd);
endtask

task automatic write_word(input logic [3:0] reg_num, input logic [15:0] w);
    write_byte(reg_num, 1'b0, w[15:8]);   // even byte is high, only latched
    write_byte(reg_num, 1'b1, w[7:0]);    // odd byte commits
endtask

task automatic read_byte(input logic [3:0] reg_num, input logic odd, output logic [7:0] b);
    bus_access(1'b1, reg_num, odd, 8'h00, b);
endtask

// poll status bit 2 until the vram access is done
task automatic wait_not_busy();
    logic [7:0] st;
    int         n;
    n  = 0;
    st = 8'h04;
    while (st[2] && n < 100) begin
        read_byte(R_STATUS, 1'b1, st);
        n++;
    end
    assert (!st[2]) else begin
        errors++;
        $display("%0t timeout, mem_busy never went low", $time);
    end
endtask

task automatic wait_vsync_rise();
    logic prev;
    int   n;
    prev = 1'b1;          // need a real low to high step
    n    = 0;
    while (!(sync.vsync && !prev) && n < 400) begin
        prev = sync.vsync;
        @(negedge clk);
        n++;
    end
    assert (sync.vsync && !prev) else begin
        errors++;
        $display("%0t timeout, no rising edge on vsync", $time);
    end
endtask

task automatic count_pulses(input int cycles, output int pulses);
    pulses = 0;
    repeat (cycles) begin
        @(negedge clk);
        if (bus_intr) pulses++;
    end
endtask

task automatic check_outputs_low();
    check_value("bus_intr_o", 16'(bus_intr), 16'h0000);
    check_value("sync_o.de", 16'(sync.de), 16'h0000);
    check_value("sync_o.hsync", 16'(sync.hsync), 16'h0000);
    check_value("sync_o.vsync", 16'(sync.vsync), 16'h0000);
    check_value("rgb_o", 16'(rgb), 16'h0000);
endtask

// one frame from vsync rise to vsync rise, geometry and pixels
task automatic check_frame();
    int          cycles;
    int          x;
    int          y;
    int          hs_run;
    int          hs_lines;
    int          vs_cycles;
    logic        prev_de;
    logic        prev_hs;
    logic        prev_vs;
    logic [15:0] word;
    logic [7:0]  idx;
    cycles    = 0;
    x         = 0;
    y         = 0;
    hs_run    = 0;
    hs_lines  = 0;
    vs_cycles = 0;
    prev_de   = 1'b0;
    prev_hs   = 1'b0;
    wait_vsync_rise();
    do begin
        if (sync.de) begin
            word = vram_model[8'(8 * y + x / 2)];     // two pixels per word
            idx  = x[0] ? word[7:0] : word[15:8];      // even x takes the high byte
            check_value("rgb_o", 16'(rgb), 16'(color_model[idx][11:0]));
            x++;
        end else begin
            check_value("rgb_o", 16'(rgb), 16'h0000);  // blanked
        end
        if (!sync.de && prev_de) begin
            check_value("de_o cycles per line", 16'(x), 16'd16);
            x = 0;
            y++;
        end
        if (sync.hsync) hs_run++;
        if (!sync.hsync && prev_hs) begin
            check_value("sync_o.hsync cycles per line", 16'(hs_run), 16'd3);
            hs_run = 0;
            hs_lines++;
        end
        if (sync.vsync) vs_cycles++;
        prev_de = sync.de;
        prev_hs = sync.hsync;
        prev_vs = sync.vsync;
        @(negedge clk);
        cycles++;
    end while (!(sync.vsync && !prev_vs) && cycles < 400);
    check_value("vsync rise to rise", 16'(cycles), 16'd288);
    check_value("de_o lines per frame", 16'(y), 16'd8);
    check_value("hsync pulses per frame", 16'(hs_lines), 16'd12);
    check_value("sync_o.vsync cycles", 16'(vs_cycles), 16'd48);
endtask

initial begin
    logic [31:0] r;
    logic [15:0] w;
    logic [7:0]  a;
    logic [7:0]  hi;
    logic [7:0]  lo;
    logic [7:0]  rb;
    vaddr_t      rt_addr [$];
    int          pulses;
    rng_state = 32'h8c3f_9f52;
    checks    = 0;
    errors    = 0;
    reset_i   = 1'b1;
    bus       = '{cs_n: 1'b1, rd_nwr: 1'b0, reg_num: 4'h0, bytesel: 1'b0, data: 8'h00};

    repeat (5) begin
        @(negedge clk);
        check_outputs_low();
    end
    reset_i = 1'b0;
    @(negedge clk);
    check_outputs_low();    // pipeline still empty

    // random words to random addresses, read back later
    for (int i = 0; i < 24; i++) begin
        r = next_rand();
        a = r[7:0];
        w = r[23:8];
        rt_addr.push_back(a);
        write_word(R_WR_ADDR, {8'h00, a});
        write_word(R_WR_DATA, w);
        vram_model[a] = w;
        wait_not_busy();
    end
    foreach (rt_addr[i]) begin
        write_word(R_RD_ADDR, {8'h00, rt_addr[i]});
        wait_not_busy();
        read_byte(R_RD_DATA, 1'b0, hi);
        read_byte(R_RD_DATA, 1'b1, lo);
        check_value("RD_DATA", {hi, lo}, vram_model[rt_addr[i]]);
    end

    // whole color memory, xr address auto increments
    write_word(R_XR_ADDR, 16'h0000);
    for (int i = 0; i < 256; i++) begin
        r = next_rand();
        write_word(R_XR_DATA, r[15:0]);
        color_model[8'(i)] = r[15:0];
    end

    // 64 display words from address 0
    write_word(R_WR_ADDR, 16'h0000);
    for (int i = 0; i < 64; i++) begin
        r = next_rand();
        wait_not_busy();
        write_word(R_WR_DATA, r[15:0]);
        vram_model[8'(i)] = r[15:0];
    end
    wait_not_busy();
    check_frame();

    // frame interrupt only, status cleared just after vsync
    write_byte(R_INT_CTRL, 1'b0, 8'h01);
    wait_vsync_rise();
    write_byte(R_INT_CTRL, 1'b1, 8'h03);
    count_pulses(288, pulses);
    check_value("bus_intr_o pulses per frame", 16'(pulses), 16'd1);

    // in vblank, well clear of the next trigger
    wait_vsync_rise();
    read_byte(R_INT_CTRL, 1'b1, rb);
    check_value("INT_CTRL odd byte", 16'(rb), 16'h0003);   // line bit sticky though masked
    read_byte(R_INT_CTRL, 1'b0, rb);
    check_value("INT_CTRL even byte", 16'(rb), 16'h0000);
    write_byte(R_INT_CTRL, 1'b1, 8'h01);
    read_byte(R_INT_CTRL, 1'b1, rb);
    check_value("INT_CTRL after frame clear", 16'(rb), 16'h0002);
    write_byte(R_INT_CTRL, 1'b1, 8'h02);
    read_byte(R_INT_CTRL, 1'b1, rb);
    check_value("INT_CTRL after line clear", 16'(rb), 16'h0000);

    // mask zero, nothing reaches the bus
    write_byte(R_INT_CTRL, 1'b0, 8'h00);
    write_byte(R_INT_CTRL, 1'b1, 8'h03);
    count_pulses(300, pulses);
    check_value("bus_intr_o pulses masked", 16'(pulses), 16'd0);

    $display("checks: %0d errors: %0d", checks, errors);
    if (errors == 0) begin
        $display("Simulation finished: PASS");
    end else begin
        $display("Simulation finished: FAIL");
    end
    $finish;
end

endmodule

//--- vid_pkg.sv
package vid_pkg;

// tiny test mode geometry
localparam int H_VISIBLE = 16;
localparam int H_FRONT   = 2;
localparam int H_SYNC    = 3;
localparam int H_BACK    = 3;
localparam int H_TOTAL   = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;     // 24 pixels per line

localparam int V_VISIBLE = 8;
localparam int V_FRONT   = 1;
localparam int V_SYNC    = 2;
localparam int V_BACK    = 1;
localparam int V_TOTAL   = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;     // 12 lines per frame

// memories
localparam int VRAM_AW        = 8;
localparam int COLOR_AW       = 8;
localparam int WORDS_PER_LINE = H_VISIBLE / 2;      // two pixels per word

// host register numbers
localparam logic [3:0] R_INT_CTRL = 4'h0;
localparam logic [3:0] R_STATUS   = 4'h1;
localparam logic [3:0] R_WR_ADDR  = 4'h2;
localparam logic [3:0] R_WR_DATA  = 4'h3;
localparam logic [3:0] R_RD_ADDR  = 4'h4;
localparam logic [3:0] R_RD_DATA  = 4'h5;
localparam logic [3:0] R_XR_ADDR  = 4'h6;
localparam logic [3:0] R_XR_DATA  = 4'h7;

// interrupt bits
localparam int FRAME_INTR = 0;
localparam int LINE_INTR  = 1;

typedef logic [15:0]         word_t;
typedef logic [VRAM_AW-1:0]  vaddr_t;
typedef logic [COLOR_AW-1:0] color_t;
typedef logic [4:0]          hpos_t;
typedef logic [3:0]          vpos_t;
typedef logic [1:0]          intr_t;

typedef struct packed {
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
} rgb_t;

// color entry as seen by the display, alpha ignored
typedef struct packed {
    logic [3:0] alpha;
    rgb_t       rgb;
} argb_t;

// host writes raw words, display reads rgb
typedef union packed {
    word_t raw;
    argb_t argb;
} color_word_u;

typedef struct packed {
    logic       cs_n;       // access strobe, active low
    logic       rd_nwr;     // 1 = read
    logic [3:0] reg_num;
    logic       bytesel;    // 0 = even (high) byte
    logic [7:0] data;
} bus_req_t;

typedef struct packed {
    logic   sel;
    logic   wr;
    vaddr_t addr;
    word_t  data;
} mem_req_t;

typedef struct packed {
    logic hsync;
    logic vsync;
    logic de;
} sync_t;

typedef struct packed {
    logic       mask_wr;    // even byte of INT_CTRL
    logic       clear_wr;   // odd byte of INT_CTRL
    logic [7:0] value;
} intr_cmd_t;

endpackage

//--- video_timing.sv
`timescale 1ns/1ps

module video_timing import vid_pkg::*; (
    input  logic  clk,
    input  logic  reset_i,
    output hpos_t h_pos_o,
    output vpos_t v_pos_o,
    output sync_t sync_o,
    output logic  hblank_o,
    output logic  vblank_o,
    output intr_t trigger_o
);

logic h_last;       // last pixel of the line
logic v_last;       // last line of the frame

assign h_last = (h_pos_o == hpos_t'(H_TOTAL - 1));
assign v_last = (v_pos_o == vpos_t'(V_TOTAL - 1));

always_ff @(posedge clk) begin
    if (reset_i) begin
        // park on the final pixel so the first frame starts right after reset
        h_pos_o <= hpos_t'(H_TOTAL - 1);
        v_pos_o <= vpos_t'(V_TOTAL - 1);
    end else begin
        h_pos_o <= h_last ? '0 : h_pos_o + 1'b1;
        if (h_last) begin
            v_pos_o <= v_last ? '0 : v_pos_o + 1'b1;
        end
    end
end

assign hblank_o = (h_pos_o >= hpos_t'(H_VISIBLE));
assign vblank_o = (v_pos_o >= vpos_t'(V_VISIBLE));

always_comb begin
    sync_o.hsync = (h_pos_o >= hpos_t'(H_VISIBLE + H_FRONT)) &&
                   (h_pos_o <  hpos_t'(H_VISIBLE + H_FRONT + H_SYNC));     // active high
    sync_o.vsync = (v_pos_o >= vpos_t'(V_VISIBLE + V_FRONT)) &&
                   (v_pos_o <  vpos_t'(V_VISIBLE + V_FRONT + V_SYNC));
    sync_o.de    = !hblank_o && !vblank_o;
end

always_comb begin
    trigger_o             = '0;
    trigger_o[FRAME_INTR] = (v_pos_o == vpos_t'(V_VISIBLE)) && (h_pos_o == '0);
    trigger_o[LINE_INTR]  = !vblank_o && (h_pos_o == hpos_t'(H_VISIBLE));  // first hblank pixel
end

endmodule

//--- video_top.sv
`timescale 1ns/1ps

module video_top import vid_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,
    input  bus_req_t   bus_i,
    output logic [7:0] bus_data_o,
    output logic       bus_intr_o,
    output rgb_t       rgb_o,
    output sync_t      sync_o
);

mem_req_t  regs_req;
logic      regs_ack;
word_t     vram_data;       // shared by display and host reads
logic      xr_wr;
color_t    xr_addr;
word_t     xr_data;
intr_cmd_t intr_cmd;
intr_t     intr_status;
intr_t     trigger;
hpos_t     h_pos;
vpos_t     v_pos;
sync_t     timing_sync;     // at position
sync_t     fetch_sync;      // two cycles later
logic      hblank;
logic      vblank;
logic      video_sel;
vaddr_t    video_addr;
color_t    color_index;

bus_regs bus_regs (
    .clk(clk),
    .reset_i(reset_i),
    .bus_i(bus_i),
    .bus_data_o(bus_data_o),
    .regs_req_o(regs_req),
    .regs_ack_i(regs_ack),
    .vram_data_i(vram_data),
    .xr_wr_o(xr_wr),
    .xr_addr_o(xr_addr),
    .xr_data_o(xr_data),
    .intr_cmd_o(intr_cmd),
    .intr_status_i(intr_status),
    .hblank_i(hblank),
    .vblank_i(vblank)
);

intr_ctrl intr_ctrl (
    .clk(clk),
    .reset_i(reset_i),
    .intr_cmd_i(intr_cmd),
    .trigger_i(trigger),
    .status_o(intr_status),
    .bus_intr_o(bus_intr_o)
);

video_timing video_timing (
    .clk(clk),
    .reset_i(reset_i),
    .h_pos_o(h_pos),
    .v_pos_o(v_pos),
    .sync_o(timing_sync),
    .hblank_o(hblank),
    .vblank_o(vblank),
    .trigger_o(trigger)
);

pixel_fetch pixel_fetch (
    .clk(clk),
    .h_pos_i(h_pos),
    .v_pos_i(v_pos),
    .sync_i(timing_sync),
    .vram_sel_o(video_sel),
    .vram_addr_o(video_addr),
    .vram_data_i(vram_data),
    .color_index_o(color_index),
    .sync_o(fetch_sync)
);

vram_arb vram_arb (
    .clk(clk),
    .video_sel_i(video_sel),
    .video_addr_i(video_addr),
    .regs_req_i(regs_req),
    .regs_ack_o(regs_ack),
    .vram_data_o(vram_data)
);

color_lookup color_lookup (
    .clk(clk),
    .reset_i(reset_i),
    .xr_wr_i(xr_wr),
    .xr_addr_i(xr_addr),
    .xr_data_i(xr_data),
    .color_index_i(color_index),
    .sync_i(fetch_sync),
    .rgb_o(rgb_o),
    .sync_o(sync_o)
);

endmodule

//--- vram_arb.sv
`timescale 1ns/1ps

module vram_arb import vid_pkg::*; (
    input  logic     clk,
    input  logic     video_sel_i,
    input  vaddr_t   video_addr_i,
    input  mem_req_t regs_req_i,
    output logic     regs_ack_o,
    output word_t    vram_data_o
);

word_t vram [2**VRAM_AW];

// display always wins, host gets the gaps
assign regs_ack_o = regs_req_i.sel && !video_sel_i;

always_ff @(posedge clk) begin
    if (video_sel_i) begin
        vram_data_o <= vram[video_addr_i];
    end else if (regs_req_i.sel) begin
        if (regs_req_i.wr) begin
            vram[regs_req_i.addr] <= regs_req_i.data;  // full word, no mask
        end else begin
            vram_data_o <= vram[regs_req_i.addr];      // shared read bus
        end
    end
end

endmodule
